//--- Makefile
# Verilator flow for the direct-mapped cache

TOOL      = verilator
TOP       = tb_cache_top
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log

COMMON_FLAGS = --timing --assert --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS   = --lint-only $(COMMON_FLAGS)
BUILD_FLAGS  = --binary -j 0 --Mdir $(BUILD_DIR) $(COMMON_FLAGS)

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS)

build:
	$(TOOL) $(BUILD_FLAGS)

# pass or fail comes from the log, not from the exit status of the run
sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^SIMULATION PASSED$$" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
hw/cache_geom_pkg.sv
hw/cache_ctrl_pkg.sv
hw/cache_store.sv
hw/cache_dm.sv
hw/mem_model.sv
hw/cache_top.sv
test/tb_cache_top.sv

//--- hw/cache_ctrl_pkg.sv
`default_nettype none

package cache_ctrl_pkg;

    // controller FSM
    typedef enum logic [1:0] {
        st_lookup    = 2'd0,  // tag compare, hits served here
        st_writeback = 2'd1,  // dirty victim out to memory
        st_refill    = 2'd2   // requested block in from memory
    } cache_state_e;

    // held-request cycles before the memory pulses its response
    localparam int mem_latency = 3;
    localparam int mem_cnt_w   = $clog2(mem_latency + 1);

    // worst-case stall: lookup cycle, writeback (latency + pulse),
    // one idle cycle between transactions, refill (latency + pulse)
    localparam int miss_cycles_max = 2 * (mem_latency + 1) + 2;
    localparam int stall_cnt_w     = $clog2(miss_cycles_max + 1);

endpackage

`default_nettype wire

//--- hw/cache_dm.sv
`timescale 1ns/1ns
`default_nettype none

module cache_dm (
    input  logic                                  clk,
    input  logic                                  rst,
    // pipeline side
    input  logic [cache_geom_pkg::addr_w-1:0]     req_addr,
    input  logic [cache_geom_pkg::data_w-1:0]     req_data,
    input  logic                                  req_wen,
    input  logic                                  req_valid,
    output logic [cache_geom_pkg::data_w-1:0]     res_data,
    output logic                                  res_stall,
    // memory side, word addressed
    output logic [cache_geom_pkg::mem_addr_w-1:0] mem_req_addr,
    output logic [cache_geom_pkg::data_w-1:0]     mem_req_data,
    output logic                                  mem_req_wen,
    output logic                                  mem_req_valid,
    input  logic [cache_geom_pkg::data_w-1:0]     mem_res_data,
    input  logic                                  mem_res_valid
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    cache_state_e state_q;
    cache_state_e state_d;

    // request address fields, low offset bits ignored
    logic [tag_w-1:0]   req_tag;
    logic [index_w-1:0] req_index;

    // selected line from the store
    logic [tag_w-1:0]  rd_tag;
    logic [data_w-1:0] rd_data;
    logic              rd_valid;
    logic              rd_dirty;

    // store write port
    logic              wr_en;
    logic [data_w-1:0] wr_data;
    logic              wr_dirty;

    logic hit;
    logic gap_q;  // one idle cycle after each memory response

    logic [word_addr_w-1:0] wb_word_addr;  // victim location
    logic [word_addr_w-1:0] rf_word_addr;  // requested block

    logic [stall_cnt_w-1:0] stall_cnt;  // consecutive stalled cycles

    assign req_tag   = req_addr[offset_w+index_w +: tag_w];
    assign req_index = req_addr[offset_w +: index_w];

    assign hit = rd_valid && (rd_tag == req_tag);

    // read data straight from the line, valid on a hit
    assign res_data  = rd_data;
    assign res_stall = req_valid && ((state_q != st_lookup) || !hit);

    // write hit, or refill completion
    assign wr_en = (state_q == st_lookup && req_valid && req_wen && hit)
                || (state_q == st_refill && mem_res_valid);
    assign wr_data  = (state_q == st_refill) ? mem_res_data : req_data;
    assign wr_dirty = (state_q == st_lookup);  // refill installs clean

    cache_store u_cache_store (
        .clk      (clk),
        .rst      (rst),
        .index    (req_index),
        .rd_tag   (rd_tag),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .rd_dirty (rd_dirty),
        .wr_en    (wr_en),
        .wr_tag   (req_tag),  // refill brings the requested tag
        .wr_data  (wr_data),
        .wr_dirty (wr_dirty)
    );

    // memory request, decoded from registered state
    assign wb_word_addr = {rd_tag, req_index};
    assign rf_word_addr = {req_tag, req_index};

    assign mem_req_valid = (state_q != st_lookup) && !gap_q;
    assign mem_req_wen   = (state_q == st_writeback);
    assign mem_req_data  = rd_data;  // victim word, only used on writeback
    assign mem_req_addr  = (state_q == st_writeback) ? wb_word_addr[mem_addr_w-1:0]
                                                     : rf_word_addr[mem_addr_w-1:0];

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_lookup: begin
                if (req_valid && !hit) begin
                    // dirty victim goes out before the refill
                    state_d = (rd_valid && rd_dirty) ? st_writeback : st_refill;
                end
            end
            st_writeback: begin
                if (mem_res_valid) state_d = st_refill;
            end
            st_refill: begin
                if (mem_res_valid) state_d = st_lookup;  // replay as a hit
            end
            default: state_d = st_lookup;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_lookup;
            gap_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            gap_q   <= mem_res_valid;  // drop valid in the cycle after a pulse
        end
    end

    // stall length, saturating
    always_ff @(posedge clk) begin
        if (rst) begin
            stall_cnt <= '0;
        end else if (res_stall) begin
            if (stall_cnt != '1) stall_cnt <= stall_cnt + 1'b1;
        end else begin
            stall_cnt <= '0;
        end
    end

    // request held until the response pulse
    a_req_held: assert property (
        @(posedge clk) disable iff (rst)
        mem_req_valid && !mem_res_valid |=> mem_req_valid
    ) else $error("cache_dm: mem_req_valid dropped before response");

    // memory only answers an open request
    a_no_orphan_res: assert property (
        @(posedge clk) disable iff (rst)
        mem_res_valid |-> mem_req_valid
    ) else $error("cache_dm: mem_res_valid without a request");

    // miss bounded by two memory transactions plus overhead
    a_stall_bound: assert property (
        @(posedge clk) disable iff (rst)
        res_stall |-> stall_cnt < stall_cnt_w'(miss_cycles_max)
    ) else $error("cache_dm: stall exceeded %0d cycles in state %s",
                  miss_cycles_max, state_q.name());

endmodule

`default_nettype wire

//--- hw/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

    // pipeline side, byte addressed
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // address split: | tag | index | offset |
    localparam int offset_w = 2;  // 4-byte blocks
    localparam int index_w  = 7;  // 512 bytes / 4 bytes per block
    localparam int tag_w    = addr_w - index_w - offset_w;  // 23

    localparam int num_lines = 1 << index_w;  // 128 lines

    // backing memory, word addressed
    // only the low 12 word-address bits reach the memory
    localparam int mem_addr_w = 12;
    localparam int mem_words  = 1 << mem_addr_w;  // 4096 words, 16 KiB

    // full word address as the controller builds it, {tag, index}
    localparam int word_addr_w = tag_w + index_w;

endpackage

`default_nettype wire

//--- hw/cache_store.sv
`timescale 1ns/1ns
`default_nettype none

module cache_store (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [cache_geom_pkg::index_w-1:0] index,   // line select, read and write
    output logic [cache_geom_pkg::tag_w-1:0]   rd_tag,
    output logic [cache_geom_pkg::data_w-1:0]  rd_data,
    output logic                             rd_valid,
    output logic                             rd_dirty,
    input  logic                             wr_en,     // replace whole entry
    input  logic [cache_geom_pkg::tag_w-1:0]   wr_tag,
    input  logic [cache_geom_pkg::data_w-1:0]  wr_data,
    input  logic                             wr_dirty
);
    import cache_geom_pkg::*;

    // line array, one entry per index
    logic [tag_w-1:0]     tag_mem   [num_lines];
    logic [data_w-1:0]    data_mem  [num_lines];
    logic [num_lines-1:0] dirty_mem;

    // valid bits kept as a flat vector so reset can clear them all at once
    logic [num_lines-1:0] valid_q;

    // asynchronous read of the selected line
    assign rd_tag   = tag_mem[index];
    assign rd_data  = data_mem[index];
    assign rd_valid = valid_q[index];
    assign rd_dirty = dirty_mem[index];

    // valid bits, cleared in the reset cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[index] <= 1'b1;  // any write installs the line
        end
    end

    // payload fields, kept across reset
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[index]   <= wr_tag;
            data_mem[index]  <= wr_data;
            dirty_mem[index] <= wr_dirty;  // clean on refill, dirty on write hit
        end
    end

    // controller must hold off writes until reset is released
    a_no_write_in_reset: assert property (
        @(posedge clk) rst |-> !wr_en
    ) else $error("cache_store: write issued during reset");

endmodule

`default_nettype wire

//--- hw/cache_top.sv
`timescale 1ns/1ns
`default_nettype none

module cache_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [cache_geom_pkg::addr_w-1:0] req_addr,
    input  logic [cache_geom_pkg::data_w-1:0] req_data,
    input  logic                              req_wen,
    input  logic                              req_valid,
    output logic [cache_geom_pkg::data_w-1:0] res_data,
    output logic                              res_stall
);
    import cache_geom_pkg::*;

    // cache to memory
    logic [mem_addr_w-1:0] mem_req_addr;
    logic [data_w-1:0]     mem_req_data;
    logic                  mem_req_wen;
    logic                  mem_req_valid;
    logic [data_w-1:0]     mem_res_data;
    logic                  mem_res_valid;

    cache_dm u_cache_dm (
        .clk           (clk),
        .rst           (rst),
        .req_addr      (req_addr),
        .req_data      (req_data),
        .req_wen       (req_wen),
        .req_valid     (req_valid),
        .res_data      (res_data),
        .res_stall     (res_stall),
        .mem_req_addr  (mem_req_addr),
        .mem_req_data  (mem_req_data),
        .mem_req_wen   (mem_req_wen),
        .mem_req_valid (mem_req_valid),
        .mem_res_data  (mem_res_data),
        .mem_res_valid (mem_res_valid)
    );

    mem_model u_mem_model (
        .clk   (clk),
        .rst   (rst),
        .addr  (mem_req_addr),
        .wdata (mem_req_data),
        .wen   (mem_req_wen),
        .valid (mem_req_valid),
        .rdata (mem_res_data),
        .ready (mem_res_valid)
    );

endmodule

`default_nettype wire

//--- hw/mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module mem_model (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [cache_geom_pkg::mem_addr_w-1:0] addr,   // word address
    input  logic [cache_geom_pkg::data_w-1:0]     wdata,
    input  logic                                  wen,
    input  logic                                  valid,  // held until ready
    output logic [cache_geom_pkg::data_w-1:0]     rdata,
    output logic                                  ready   // one-cycle pulse
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    logic [data_w-1:0]    mem [mem_words];
    logic [mem_cnt_w-1:0] cnt;  // held cycles so far
    logic                 done;

    // memory starts zeroed
    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = '0;
        end
    end

    // last held cycle before the response
    assign done = valid && !ready && (cnt == mem_cnt_w'(mem_latency - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt   <= '0;
            ready <= 1'b0;
        end else begin
            ready <= done;
            if (!valid || ready || done) begin
                cnt <= '0;  // restart for the next request
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // access happens at the edge that raises ready
    always_ff @(posedge clk) begin
        if (done) begin
            if (wen) mem[addr] <= wdata;
            rdata <= mem[addr];  // read word presented with the pulse
        end
    end

    // requester keeps the address steady while waiting
    a_addr_stable: assert property (
        @(posedge clk) disable iff (rst)
        valid && $past(valid) && !$past(ready) |-> addr == $past(addr)
    ) else $error("mem_model: addr changed while request held");

endmodule

`default_nettype wire

//--- test/tb_cache_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cache_top;
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    localparam int clk_period   = 100;  // ns
    localparam int reset_cycles = 5;
    localparam int rand_count   = 2000;
    localparam int write_pct    = 40;
    // directed requests 1 + 2 + 2 + 4, plus slack for idle cycles
    localparam int num_requests = 9 + rand_count + 8;
    localparam int watchdog_ns  = num_requests * (miss_cycles_max + 2) * clk_period
                                + reset_cycles * clk_period;

    logic              clk;
    logic              rst;
    logic [addr_w-1:0] req_addr;
    logic [data_w-1:0] req_data;
    logic              req_wen;
    logic              req_valid;
    logic [data_w-1:0] res_data;
    logic              res_stall;

    logic [data_w-1:0] ref_mem [mem_words];  // flat reference, word addressed
    integer            seed;
    string             test_name;
    int                test_errs;
    int                pass_cnt;
    int                fail_cnt;
    cache_state_e      dbg_state;  // controller state for debug lines

    assign dbg_state = UUT.u_cache_dm.state_q;

    cache_top UUT (
        .clk       (clk),
        .rst       (rst),
        .req_addr  (req_addr),
        .req_data  (req_data),
        .req_wen   (req_wen),
        .req_valid (req_valid),
        .res_data  (res_data),
        .res_stall (res_stall)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    // one request, driven at posedge, stall sampled at negedge
    task automatic access(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                          input logic wen, output logic [data_w-1:0] rdata,
                          output int stalls);
        stalls = 0;
        @(posedge clk);
        req_addr  <= addr;
        req_data  <= data;
        req_wen   <= wen;
        req_valid <= 1'b1;
        @(negedge clk);
        while (res_stall) begin
            stalls++;  // miss still in flight
            @(negedge clk);
        end
        rdata = res_data;  // completes at the next posedge
        if (wen) ref_mem[addr[13:2]] = data;
    endtask

    task automatic check_value(input logic [data_w-1:0] exp, input logic [data_w-1:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s: expected %h, actual %h", test_name, exp, act);
            test_errs++;
        end
    endtask

    // read and compare with the flat model
    task automatic read_check(input logic [addr_w-1:0] addr, output int stalls);
        logic [data_w-1:0] exp;
        logic [data_w-1:0] got;
        exp = ref_mem[addr[13:2]];
        access(addr, '0, 1'b0, got, stalls);
        check_value(exp, got);
    endtask

    task automatic check_no_stall(input int stalls);
        assert (stalls == 0) else begin
            $display("CHECK FAILED %s: expected 0 stall cycles, actual %0d", test_name, stalls);
            test_errs++;
        end
    endtask

    task automatic check_stalled(input int stalls);
        assert (stalls > 0) else begin
            $display("%s: a miss completed without any stall, controller in %s",
                     test_name, dbg_state.name());
            test_errs++;
        end
    endtask

    // drop req_valid, stall must be low
    task automatic idle_cycle();
        @(posedge clk);
        req_valid <= 1'b0;
        req_wen   <= 1'b0;
        @(negedge clk);
        assert (res_stall == 1'b0) else begin
            $display("CHECK FAILED %s: expected res_stall 0, actual %b", test_name, res_stall);
            test_errs++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %s passed", test_name);
        end else begin
            fail_cnt++;
            $display("test %s failed with %0d errors", test_name, test_errs);
        end
    endtask

    // hang guard, sized from the request count
    initial begin
        #(watchdog_ns);
        $display("run timed out after %0d ns before all requests completed", watchdog_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int                stalls;
        logic [addr_w-1:0] a;
        logic [data_w-1:0] wdata;
        logic [data_w-1:0] got;
        seed      = 32'h515b;
        pass_cnt  = 0;
        fail_cnt  = 0;
        req_addr  = '0;
        req_data  = '0;
        req_wen   = 1'b0;
        req_valid = 1'b0;
        rst       = 1'b1;
        for (int i = 0; i < mem_words; i++) ref_mem[i] = '0;  // memory starts zeroed
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;

        start_test("reset_idle");
        idle_cycle();
        read_check(32'h0000_0100, stalls);  // cold miss, reads zero
        end_test();

        start_test("read_miss_then_hit");
        a = 32'h0000_0240;
        read_check(a, stalls);
        check_stalled(stalls);
        read_check(a, stalls);  // now resident
        check_no_stall(stalls);
        end_test();

        start_test("write_hit");
        access(a, 32'hdead_beef, 1'b1, got, stalls);
        check_no_stall(stalls);
        read_check(a, stalls);
        check_no_stall(stalls);
        end_test();

        start_test("dirty_eviction");
        a = 32'h0000_0310;
        access(a + 512, 32'h1234_5678, 1'b1, got, stalls);
        access(a, 32'h0bad_cafe, 1'b1, got, stalls);  // evicts a+512 dirty
        read_check(a + 512, stalls);  // evicts a dirty
        check_stalled(stalls);
        read_check(a, stalls);
        check_stalled(stalls);
        end_test();

        start_test("random_mix");
        for (int n = 0; n < rand_count; n++) begin
            a     = ({$random(seed)} % mem_words) << 2;  // aligned, below 16 KiB
            wdata = $random(seed);
            if (({$random(seed)} % 100) < write_pct) begin
                access(a, wdata, 1'b1, got, stalls);
            end else begin
                read_check(a, stalls);
            end
        end
        idle_cycle();
        end_test();

        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
